//--- design/operand_fetch.sv
// Operand fetch stage
`timescale 1ns/1ps

module operand_fetch #(
  parameter int unsigned NUM_WORDS = 32
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inst_valid_i,
  input  rf_pkg::rf_inst_t   inst_i,
  rf_read_if.requester       rd_port,
  rf_write_if.monitor        wr_mon,
  output logic               op_valid_o,
  output rf_pkg::rf_data_t   op_rs1_o,
  output rf_pkg::rf_data_t   op_rs2_o,
  output rf_pkg::rf_addr_t   op_rd_o
);
  import rf_pkg::*;

  // Decoded register indices, slot 0 is rs1 and slot 1 is rs2
  rf_addr_t rs_addr [RF_NUM_READ_PORTS];
  rf_addr_t rd_addr;

  // Source data after forwarding
  rf_data_t rs_data [RF_NUM_READ_PORTS];

  // Same-cycle write that should bypass the register file
  function automatic logic fwd_hit(rf_addr_t src, logic we, rf_addr_t waddr);
    return we && (waddr == src) && (src != '0) && (32'(src) < NUM_WORDS);
  endfunction

  // --------------------
  // Field extraction
  // --------------------

  assign rs_addr[0] = inst_i[RS1_MSB:RS1_LSB];
  assign rs_addr[1] = inst_i[RS2_MSB:RS2_LSB];
  assign rd_addr    = inst_i[RD_MSB:RD_LSB];

  // Read path is purely combinational
  for (genvar r = 0; r < RF_NUM_READ_PORTS; r++) begin : gen_raddr
    assign rd_port.raddr[r] = rs_addr[r];
  end

  // --------------------
  // Forwarding
  // --------------------

  // Port loop runs upward so port 1 has the last word
  always_comb begin
    for (int r = 0; r < RF_NUM_READ_PORTS; r++) begin
      rs_data[r] = rd_port.rdata[r];
      for (int p = 0; p < RF_NUM_WRITE_PORTS; p++) begin
        if (fwd_hit(rs_addr[r], wr_mon.we[p], wr_mon.waddr[p])) begin
          rs_data[r] = wr_mon.wdata[p];
        end
      end
    end
  end

  // --------------------
  // Output register
  // --------------------

  // Valid is a one-cycle echo of the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid_o <= 1'b0;
    end else begin
      op_valid_o <= inst_valid_i;
    end
  end

  // Operands and rd only move on a strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_rs1_o <= '0;
      op_rs2_o <= '0;
      op_rd_o  <= '0;
    end else if (inst_valid_i) begin
      op_rs1_o <= rs_data[0];
      op_rs2_o <= rs_data[1];
      op_rd_o  <= rd_addr;
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Fixed one-cycle latency
  a_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    op_valid_o == $past(inst_valid_i));

endmodule

//--- design/register_file.sv
// Flip-flop register file
`timescale 1ns/1ps

module register_file #(
  parameter int unsigned NUM_WORDS = 32
) (
  input  logic       clk,
  input  logic       rst_n,
  rf_read_if.regfile  rd_port,
  rf_write_if.regfile wr_port
);
  import rf_pkg::*;

  // Register storage where entry 0 stays zero
  rf_data_t mem [NUM_WORDS];

  // Per-port one-hot write enables over the full address space
  logic [RF_NUM_WRITE_PORTS-1:0][RF_MAX_WORDS-1:0] we_dec;

  // Address lies inside the implemented range
  function automatic logic addr_ok(rf_addr_t addr);
    return 32'(addr) < NUM_WORDS;
  endfunction

  // --------------------
  // Read ports
  // --------------------

  // Combinational read where unimplemented addresses give zero
  for (genvar r = 0; r < RF_NUM_READ_PORTS; r++) begin : gen_read
    assign rd_port.rdata[r] = addr_ok(rd_port.raddr[r]) ? mem[rd_port.raddr[r]] : '0;
  end

  // --------------------
  // Write decode
  // --------------------

  // Enable gated by the port enable and by the implemented range
  for (genvar p = 0; p < RF_NUM_WRITE_PORTS; p++) begin : gen_wdec_port
    for (genvar w = 0; w < RF_MAX_WORDS; w++) begin : gen_wdec_word
      assign we_dec[p][w] = wr_port.we[p] && addr_ok(wr_port.waddr[p]) &&
                            (wr_port.waddr[p] == rf_addr_t'(w));
    end
  end

  // --------------------
  // Register update
  // --------------------

  // Hardwired zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem[0] <= '0;
    end else begin
      mem[0] <= '0;
    end
  end

  for (genvar i = 1; i < NUM_WORDS; i++) begin : gen_reg
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem[i] <= '0;
      end else begin
        // Later port overrides earlier one
        for (int p = 0; p < RF_NUM_WRITE_PORTS; p++) begin
          if (we_dec[p][i]) begin
            mem[i] <= wr_port.wdata[p];
          end
        end
      end
    end
  end

  // --------------------
  // Checks
  // --------------------

  // Address 0 reads zero whatever was written before
  for (genvar r = 0; r < RF_NUM_READ_PORTS; r++) begin : gen_chk_read
    a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_port.raddr[r] == '0) |-> (rd_port.rdata[r] == '0));
  end

  // No enable above the implemented range
  for (genvar p = 0; p < RF_NUM_WRITE_PORTS; p++) begin : gen_chk_write
    a_no_unimpl_we: assert property (@(posedge clk) disable iff (!rst_n)
      (we_dec[p] >> NUM_WORDS) == '0);
  end

endmodule

//--- design/rf_pkg.sv
// Register file shared types
package rf_pkg;

  // --------------------
  // Widths
  // --------------------

  // Register index width covers RV32I
  localparam int unsigned RF_ADDR_W = 5;
  localparam int unsigned RF_DATA_W = 32;
  localparam int unsigned RF_INST_W = 32;

  // Full address space, upper bound for NUM_WORDS
  localparam int unsigned RF_MAX_WORDS = 2 ** RF_ADDR_W;

  // Port counts are fixed by the datapath
  localparam int unsigned RF_NUM_READ_PORTS  = 2;
  localparam int unsigned RF_NUM_WRITE_PORTS = 2;

  // --------------------
  // Types
  // --------------------

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;
  typedef logic [RF_DATA_W-1:0] rf_data_t;
  typedef logic [RF_INST_W-1:0] rf_inst_t;

  // --------------------
  // Instruction fields
  // --------------------

  // Destination register
  localparam int unsigned RD_LSB  = 7;
  localparam int unsigned RD_MSB  = 11;
  // First source register
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS1_MSB = 19;
  // Second source register
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned RS2_MSB = 24;

endpackage

//--- design/rf_read_if.sv
// Register file read bus
`timescale 1ns/1ps

interface rf_read_if;
  import rf_pkg::*;

  // One address and one data word per read port
  rf_addr_t raddr [RF_NUM_READ_PORTS];
  rf_data_t rdata [RF_NUM_READ_PORTS];

  // Operand fetch side, drives the addresses
  modport requester (
    output raddr,
    input  rdata
  );

  // Register file side, returns data combinationally
  modport regfile (
    input  raddr,
    output rdata
  );

endinterface

//--- design/rf_subsys_top.sv
// Register file subsystem top
`timescale 1ns/1ps

module rf_subsys_top #(
  parameter int unsigned NUM_WORDS = 32
) (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // Instruction strobe
  input  logic                                   inst_valid_i,
  input  rf_pkg::rf_inst_t                       inst_i,

  // Writeback ports
  input  logic [rf_pkg::RF_NUM_WRITE_PORTS-1:0]  wb_we_i,
  input  rf_pkg::rf_addr_t                       wb_waddr0_i,
  input  rf_pkg::rf_addr_t                       wb_waddr1_i,
  input  rf_pkg::rf_data_t                       wb_wdata0_i,
  input  rf_pkg::rf_data_t                       wb_wdata1_i,

  // Registered operands
  output logic                                   op_valid_o,
  output rf_pkg::rf_data_t                       op_rs1_o,
  output rf_pkg::rf_data_t                       op_rs2_o,
  output rf_pkg::rf_addr_t                       op_rd_o
);

  // --------------------
  // Internal buses
  // --------------------

  rf_read_if  rd_bus ();
  rf_write_if wr_bus ();

  // Writeback ports onto the write bus
  assign wr_bus.we       = wb_we_i;
  assign wr_bus.waddr[0] = wb_waddr0_i;
  assign wr_bus.waddr[1] = wb_waddr1_i;
  assign wr_bus.wdata[0] = wb_wdata0_i;
  assign wr_bus.wdata[1] = wb_wdata1_i;

  // --------------------
  // Blocks
  // --------------------

  register_file #(
    .NUM_WORDS (NUM_WORDS)
  ) register_file_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_port (rd_bus.regfile),
    .wr_port (wr_bus.regfile)
  );

  // Same write bus seen again for bypass
  operand_fetch #(
    .NUM_WORDS (NUM_WORDS)
  ) operand_fetch_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .rd_port      (rd_bus.requester),
    .wr_mon       (wr_bus.monitor),
    .op_valid_o   (op_valid_o),
    .op_rs1_o     (op_rs1_o),
    .op_rs2_o     (op_rs2_o),
    .op_rd_o      (op_rd_o)
  );

endmodule

//--- design/rf_write_if.sv
// Register file write bus
`timescale 1ns/1ps

interface rf_write_if;
  import rf_pkg::*;

  // Per-port enable, address and data
  logic [RF_NUM_WRITE_PORTS-1:0] we;
  rf_addr_t                      waddr [RF_NUM_WRITE_PORTS];
  rf_data_t                      wdata [RF_NUM_WRITE_PORTS];

  // Writeback side
  modport source (
    output we,
    output waddr,
    output wdata
  );

  // Register file, commits at the next edge
  modport regfile (
    input we,
    input waddr,
    input wdata
  );

  // Forwarding logic only watches the bus
  modport monitor (
    input we,
    input waddr,
    input wdata
  );

endinterface

//--- test/tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS = 100
) (
  output logic clk_o
);

  // Free running, starts low so the first rising edge is at half a period
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #(PERIOD_NS / 2);
    clk_o = ~clk_o;
  end

endmodule

//--- test/tb_rf_subsys.sv
// Register file subsystem testbench
`timescale 1ns/1ps

module tb_rf_subsys;
  import rf_pkg::*;

  localparam int unsigned NUM_WORDS   = 32;
  localparam int unsigned RAND_CYCLES = 2000;
  localparam int unsigned WAIT_LIMIT  = 20;

  logic                          clk;
  logic                          rst_n;
  logic                          inst_valid_i;
  rf_inst_t                      inst_i;
  logic [RF_NUM_WRITE_PORTS-1:0] wb_we_i;
  rf_addr_t                      wb_waddr0_i;
  rf_addr_t                      wb_waddr1_i;
  rf_data_t                      wb_wdata0_i;
  rf_data_t                      wb_wdata1_i;
  logic                          op_valid_o;
  rf_data_t                      op_rs1_o;
  rf_data_t                      op_rs2_o;
  rf_addr_t                      op_rd_o;

  // Reference register contents
  rf_data_t model [NUM_WORDS];

  // Result expected one cycle after the last strobe
  rf_data_t exp_rs1;
  rf_data_t exp_rs2;
  rf_addr_t exp_rd;
  logic     exp_pending;

  integer   seed;
  int       err_count;

  tb_clock_gen #(.PERIOD_NS(100)) clock_inst (.clk_o(clk));

  rf_subsys_top #(.NUM_WORDS(NUM_WORDS)) rf_subsys_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_we_i      (wb_we_i),
    .wb_waddr0_i  (wb_waddr0_i),
    .wb_waddr1_i  (wb_waddr1_i),
    .wb_wdata0_i  (wb_wdata0_i),
    .wb_wdata1_i  (wb_wdata1_i),
    .op_valid_o   (op_valid_o),
    .op_rs1_o     (op_rs1_o),
    .op_rs2_o     (op_rs2_o),
    .op_rd_o      (op_rd_o)
  );

  // --------------------
  // Compare tasks
  // --------------------

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic check_data(string name, rf_data_t exp, rf_data_t act);
    if (act !== exp) begin
      err_count++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(string name, rf_addr_t exp, rf_addr_t act);
    if (act !== exp) begin
      err_count++;
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_valid(string name, logic exp, logic act);
    if (act !== exp) begin
      err_count++;
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  // --------------------
  // Reference model
  // --------------------

  // Stored value overlaid with same-cycle writes, port 1 applied last
  function automatic rf_data_t source_value(rf_addr_t a, logic [1:0] we,
                                            rf_addr_t wa0, rf_addr_t wa1,
                                            rf_data_t wd0, rf_data_t wd1);
    rf_data_t v;
    v = model[a];
    if (we[0] && wa0 == a) v = wd0;
    if (we[1] && wa1 == a) v = wd1;
    // x0 never changes
    if (a == '0) v = '0;
    return v;
  endfunction

  // rs1 at 19:15, rs2 at 24:20, rd at 11:7, other bits random
  function automatic rf_inst_t make_inst(rf_addr_t rs1, rf_addr_t rs2, rf_addr_t rd);
    rf_inst_t w;
    w = $random(seed);
    w[19:15] = rs1;
    w[24:20] = rs2;
    w[11:7]  = rd;
    return w;
  endfunction

  // One cycle of stimulus, entered and left 10 ns after a rising edge
  task automatic drive_cycle(logic valid, rf_inst_t inst, logic [1:0] we,
                             rf_addr_t wa0, rf_addr_t wa1, rf_data_t wd0, rf_data_t wd1);
    inst_valid_i = valid;
    inst_i       = inst;
    wb_we_i      = we;
    wb_waddr0_i  = wa0;
    wb_waddr1_i  = wa1;
    wb_wdata0_i  = wd0;
    wb_wdata1_i  = wd1;
    exp_pending  = valid;
    if (valid) begin
      exp_rs1 = source_value(inst[19:15], we, wa0, wa1, wd0, wd1);
      exp_rs2 = source_value(inst[24:20], we, wa0, wa1, wd0, wd1);
      exp_rd  = inst[11:7];
    end
    // Writes commit at the closing edge, port 0 first
    if (we[0] && wa0 != '0) model[wa0] = wd0;
    if (we[1] && wa1 != '0) model[wa1] = wd1;
    @(posedge clk);
    #10ns;
    inst_valid_i = 1'b0;
    wb_we_i      = '0;
  endtask

  task automatic wait_valid(string name);
    int n;
    n = 0;
    while (op_valid_o !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout in %s: the op_valid_o strobe never came", name);
        abort_run();
      end
      @(posedge clk);
      #10ns;
      n++;
    end
  endtask

  task automatic check_result(string name);
    check_data({name, " rs1"}, exp_rs1, op_rs1_o);
    check_data({name, " rs2"}, exp_rs2, op_rs2_o);
    check_addr({name, " rd"}, exp_rd, op_rd_o);
  endtask

  // Strobe one instruction with optional writes, then check its operands
  task automatic fetch(string name, rf_addr_t rs1, rf_addr_t rs2, logic [1:0] we,
                       rf_addr_t wa0, rf_addr_t wa1, rf_data_t wd0, rf_data_t wd1);
    rf_inst_t inst;
    inst = make_inst(rs1, rs2, rf_addr_t'($random(seed)));
    drive_cycle(1'b1, inst, we, wa0, wa1, wd0, wd1);
    wait_valid(name);
    check_result(name);
  endtask

  // --------------------
  // Stimulus
  // --------------------

  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #10ns;
    rst_n = 1'b1;
  end

  initial begin
    int       i;
    int       n;
    rf_data_t d0;
    rf_data_t d1;
    seed         = 32'ha446;
    err_count    = 0;
    exp_pending  = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    wb_we_i      = '0;
    wb_waddr0_i  = '0;
    wb_waddr1_i  = '0;
    wb_wdata0_i  = '0;
    wb_wdata1_i  = '0;
    for (i = 0; i < NUM_WORDS; i++) model[i] = '0;

    // Release from reset, sampled on the edge
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n == WAIT_LIMIT) begin
        $display("Timeout: reset was never released");
        abort_run();
      end
      @(posedge clk);
      n++;
    end
    #10ns;

    // Reset state
    check_valid("reset valid", 1'b0, op_valid_o);
    check_data("reset rs1", '0, op_rs1_o);
    check_data("reset rs2", '0, op_rs2_o);
    check_addr("reset rd", '0, op_rd_o);
    fetch("reset fetch", rf_addr_t'($random(seed)), rf_addr_t'($random(seed)),
          2'b00, '0, '0, '0, '0);

    // Write then read every register through port 0
    for (i = 1; i < NUM_WORDS; i++) begin
      d0 = $random(seed);
      drive_cycle(1'b0, '0, 2'b01, rf_addr_t'(i), '0, d0, '0);
      fetch("write read", rf_addr_t'(i), rf_addr_t'(i), 2'b00, '0, '0, '0, '0);
    end

    // x0 ignores writes, also on the bypass path
    d0 = $random(seed);
    d1 = $random(seed);
    drive_cycle(1'b0, '0, 2'b11, '0, '0, d0, d1);
    fetch("zero reg", '0, '0, 2'b00, '0, '0, '0, '0);
    fetch("zero fwd", '0, '0, 2'b11, '0, '0, d1, d0);

    // Both ports on one register
    drive_cycle(1'b0, '0, 2'b11, 5'd5, 5'd5, d0, d1);
    fetch("priority", 5'd5, 5'd5, 2'b00, '0, '0, '0, '0);

    // Same-cycle forwarding
    fetch("fwd port0", 5'd7, 5'd9, 2'b01, 5'd7, '0, d1, '0);
    fetch("fwd port1", 5'd12, 5'd9, 2'b10, '0, 5'd9, '0, d0);
    fetch("fwd both", 5'd10, 5'd10, 2'b11, 5'd10, 5'd10, d0, d1);

    // Random mix, valid checked every cycle for exact latency
    drive_cycle(1'b0, '0, 2'b00, '0, '0, '0, '0);
    for (i = 0; i < RAND_CYCLES; i++) begin
      check_valid("random valid", exp_pending, op_valid_o);
      if (exp_pending) check_result("random");
      drive_cycle((($random(seed) & 3) != 0), rf_inst_t'($random(seed)),
                  2'($random(seed)), rf_addr_t'($random(seed)), rf_addr_t'($random(seed)),
                  rf_data_t'($random(seed)), rf_data_t'($random(seed)));
    end
    check_valid("random valid", exp_pending, op_valid_o);
    if (exp_pending) check_result("random");

    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      abort_run();
    end
    $finish;
  end

endmodule

//--- vlog.f
design/rf_pkg.sv
design/rf_read_if.sv
design/rf_write_if.sv
design/register_file.sv
design/operand_fetch.sv
design/rf_subsys_top.sv
test/tb_clock_gen.sv
test/tb_rf_subsys.sv
